/* Bender.yml */
package:
  name: sata_stack

sources:
  - design/sata_prim_pkg.sv
  - design/sata_cmd_pkg.sv
  - design/sata_crc.sv
  - design/sata_phy_layer.sv
  - design/sata_link_layer.sv
  - design/sata_transport_layer.sv
  - design/sata_command_layer.sv
  - design/sata_stack.sv
  - target: simulation
    files:
      - verif/sata_stack_asserts.sv
      - verif/tb_sata_stack.sv

/* design/sata_cmd_pkg.sv */
// SATA register FIS definitions
package sata_cmd_pkg;

  localparam int LBA_W      = 48;
  localparam int COUNT_W    = 16;
  localparam int FEATURES_W = 16;

  typedef logic [LBA_W-1:0]      lba_t;
  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [FEATURES_W-1:0] features_t;

  // Register FIS length in dwords
  localparam int FIS_DWORDS = 5;

  // LBA addressing bit in the device register
  localparam logic [7:0] DEVICE_LBA_MODE = 8'h40;

  localparam int STATUS_ERR_BIT = 0;

  typedef enum logic [7:0] {
    REG_H2D = 8'h27,
    REG_D2H = 8'h34
  } fis_type_e;

  typedef enum logic [7:0] {
    IDENTIFY        = 8'hEC,
    FLUSH_EXT       = 8'hEA,
    READ_VERIFY_EXT = 8'h42,
    SET_FEATURES    = 8'hEF
  } ata_cmd_e;

endpackage

/* design/sata_command_layer.sv */
// SATA command layer
`timescale 1ns/10ps

module sata_command_layer import sata_cmd_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       linkup,
  input  logic       cmd_req,
  output logic       cmd_ack,
  input  ata_cmd_e   hard_drive_command,
  input  features_t  user_features,
  input  count_t     sector_count,
  input  lba_t       sector_address,
  output logic       sata_busy,
  output logic       hard_drive_error,
  output logic       link_error,
  output logic       send_stb,
  output ata_cmd_e   h2d_command,
  output features_t  h2d_features,
  output lba_t       h2d_lba,
  output count_t     h2d_sector_count,
  input  logic       d2h_reg_stb,
  input  logic [7:0] d2h_status,
  input  logic       xmit_error
);

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_BUSY,
    CMD_ACK
  } cmd_state_e;

  cmd_state_e state;
  logic       accept;

  assign accept = (state == CMD_IDLE) && cmd_req && linkup;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state            <= CMD_IDLE;
      send_stb         <= 1'b0;
      hard_drive_error <= 1'b0;
      link_error       <= 1'b0;
    end else begin
      send_stb <= accept;
      case (state)
        CMD_IDLE: begin
          if (accept) begin
            hard_drive_error <= 1'b0;
            link_error       <= 1'b0;
            state            <= CMD_BUSY;
          end
        end
        CMD_BUSY: begin
          if (xmit_error) begin
            link_error <= 1'b1;
            state      <= CMD_ACK;
          end else if (d2h_reg_stb) begin
            hard_drive_error <= d2h_status[STATUS_ERR_BIT];
            state            <= CMD_ACK;
          end
        end
        // Wait for the user to drop req
        CMD_ACK: begin
          if (!cmd_req) state <= CMD_IDLE;
        end
        default: begin
          state <= CMD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      h2d_command      <= hard_drive_command;
      h2d_features     <= user_features;
      h2d_lba          <= sector_address;
      h2d_sector_count <= sector_count;
    end
  end

  assign sata_busy = (state == CMD_BUSY);
  assign cmd_ack   = (state == CMD_ACK);

endmodule

/* design/sata_crc.sv */
// SATA frame CRC
`timescale 1ns/10ps

module sata_crc import sata_prim_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   init,
  input  logic   en,
  input  dword_t din,
  output dword_t crc
);

  dword_t base;

  // Fold one dword, MSB first
  function automatic dword_t crc_step(dword_t c, dword_t d);
    dword_t r;
    logic   fb;
    r = c;
    for (int i = DWORD_W - 1; i >= 0; i--) begin
      fb = r[DWORD_W-1] ^ d[i];
      r  = {r[DWORD_W-2:0], 1'b0};
      if (fb) begin
        r = r ^ CRC_POLY;
      end
    end
    return r;
  endfunction

  // Init together with en starts a new CRC with this dword
  assign base = init ? CRC_SEED : crc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      crc <= CRC_SEED;
    end else if (en) begin
      crc <= crc_step(base, din);
    end else if (init) begin
      crc <= CRC_SEED;
    end
  end

endmodule

/* design/sata_link_layer.sv */
// SATA link layer framing
`timescale 1ns/10ps

module sata_link_layer import sata_prim_pkg::*, sata_cmd_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       phy_ready,
  input  dword_t     rx_din,
  input  logic [3:0] rx_is_k,
  output dword_t     ll_tx_dout,
  output logic       ll_tx_is_k,
  input  logic       write_start,
  input  dword_t     write_data,
  output logic       write_strobe,
  output logic       write_done,
  output logic       xmit_error,
  output dword_t     read_data,
  output logic       read_strobe,
  output logic       read_finished,
  output logic       read_crc_ok
);

  link_state_e state;
  logic [2:0]  tx_cnt;
  dword_t      held;
  logic        held_valid;
  dword_t      tx_crc;
  dword_t      rx_crc;
  logic        det_sync;
  logic        det_x_rdy;
  logic        det_r_rdy;
  logic        det_r_ok;
  logic        det_r_err;
  logic        det_sof;
  logic        det_eof;
  logic        rx_data_vld;

  // Primitive detection on byte 0 K flag
  assign det_sync    = rx_is_k[0] && (rx_din == PRIM_SYNC);
  assign det_x_rdy   = rx_is_k[0] && (rx_din == PRIM_X_RDY);
  assign det_r_rdy   = rx_is_k[0] && (rx_din == PRIM_R_RDY);
  assign det_r_ok    = rx_is_k[0] && (rx_din == PRIM_R_OK);
  assign det_r_err   = rx_is_k[0] && (rx_din == PRIM_R_ERR);
  assign det_sof     = rx_is_k[0] && (rx_din == PRIM_SOF);
  assign det_eof     = rx_is_k[0] && (rx_din == PRIM_EOF);
  assign rx_data_vld = !rx_is_k[0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= IDLE;
      tx_cnt        <= '0;
      held_valid    <= 1'b0;
      write_done    <= 1'b0;
      xmit_error    <= 1'b0;
      read_finished <= 1'b0;
      read_crc_ok   <= 1'b0;
    end else begin
      write_done    <= 1'b0;
      xmit_error    <= 1'b0;
      read_finished <= 1'b0;
      case (state)
        // A pending transmit wins over an incoming X_RDY
        IDLE: begin
          if (phy_ready && write_start) begin
            state <= TX_RDY;
          end else if (phy_ready && det_x_rdy) begin
            state <= RX_RDY;
          end
        end
        TX_RDY: begin
          if (det_r_rdy) state <= TX_SOF;
        end
        TX_SOF: begin
          tx_cnt <= '0;
          state  <= TX_DATA;
        end
        TX_DATA: begin
          tx_cnt <= tx_cnt + 3'd1;
          if (tx_cnt == 3'(FIS_DWORDS - 1)) state <= TX_CRC;
        end
        TX_CRC: begin
          state <= TX_EOF;
        end
        TX_EOF: begin
          state <= TX_WTRM;
        end
        TX_WTRM: begin
          if (det_r_ok || det_r_err) begin
            write_done <= 1'b1;
            xmit_error <= det_r_err;
            state      <= IDLE;
          end
        end
        RX_RDY: begin
          if (det_sof) begin
            held_valid <= 1'b0;
            state      <= RX_DATA;
          end
        end
        // Last held dword at EOF is the frame CRC
        RX_DATA: begin
          if (det_eof) begin
            read_finished <= 1'b1;
            read_crc_ok   <= held_valid && (held == rx_crc);
            state         <= RX_RESP;
          end else if (rx_data_vld) begin
            held_valid <= 1'b1;
          end
        end
        RX_RESP: begin
          if (det_sync) state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // One-slot delay line for received payload
  always_ff @(posedge clk) begin
    if (state == RX_DATA && rx_data_vld) begin
      held <= rx_din;
    end
  end

  assign write_strobe = (state == TX_DATA);
  assign read_data    = held;
  assign read_strobe  = (state == RX_DATA) && rx_data_vld && held_valid;

  sata_crc i_tx_crc (
    .clk    (clk),
    .arst_n (arst_n),
    .init   (state == TX_SOF),
    .en     (write_strobe),
    .din    (write_data),
    .crc    (tx_crc)
  );

  sata_crc i_rx_crc (
    .clk    (clk),
    .arst_n (arst_n),
    .init   (state == RX_RDY && det_sof),
    .en     (read_strobe),
    .din    (held),
    .crc    (rx_crc)
  );

  always_comb begin
    ll_tx_dout = PRIM_SYNC;
    ll_tx_is_k = 1'b1;
    case (state)
      TX_RDY:  ll_tx_dout = PRIM_X_RDY;
      TX_SOF:  ll_tx_dout = PRIM_SOF;
      TX_DATA: begin
        ll_tx_dout = write_data;
        ll_tx_is_k = 1'b0;
      end
      TX_CRC: begin
        ll_tx_dout = tx_crc;
        ll_tx_is_k = 1'b0;
      end
      TX_EOF:  ll_tx_dout = PRIM_EOF;
      TX_WTRM: ll_tx_dout = PRIM_WTRM;
      RX_RDY:  ll_tx_dout = PRIM_R_RDY;
      RX_DATA: ll_tx_dout = PRIM_R_IP;
      RX_RESP: ll_tx_dout = read_crc_ok ? PRIM_R_OK : PRIM_R_ERR;
      default: ll_tx_dout = PRIM_SYNC;
    endcase
  end

endmodule

/* design/sata_phy_layer.sv */
// SATA OOB bring-up
`timescale 1ns/10ps

module sata_phy_layer import sata_prim_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       platform_ready,
  input  logic       comm_init_detect,
  input  logic       comm_wake_detect,
  input  dword_t     rx_din,
  input  logic [3:0] rx_is_k,
  output logic       tx_comm_reset,
  output logic       tx_comm_wake,
  output dword_t     phy_tx_dout,
  output logic       phy_tx_is_k,
  output logic       phy_ready
);

  phy_state_e state;
  logic       rx_align;

  assign rx_align = rx_is_k[0] && (rx_din == PRIM_ALIGN);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= RESET;
    end else begin
      case (state)
        RESET: begin
          if (platform_ready) state <= COMRESET;
        end
        // Hold COMRESET until the device answers with COMINIT
        COMRESET: begin
          if (comm_init_detect) state <= COMWAKE;
        end
        COMWAKE: begin
          if (comm_wake_detect) state <= WAIT_ALIGN;
        end
        // Lane is up once the device echoes ALIGN
        WAIT_ALIGN: begin
          if (rx_align) state <= READY;
        end
        READY: begin
          state <= READY;
        end
        default: begin
          state <= RESET;
        end
      endcase
    end
  end

  assign tx_comm_reset = (state == COMRESET);
  assign tx_comm_wake  = (state == COMWAKE);
  assign phy_ready     = (state == READY);

  // ALIGN during bring-up, idle SYNC afterwards
  assign phy_tx_dout = phy_ready ? PRIM_SYNC : PRIM_ALIGN;
  assign phy_tx_is_k = 1'b1;

endmodule

/* design/sata_prim_pkg.sv */
// SATA wire-level definitions
package sata_prim_pkg;

  localparam int DWORD_W = 32;

  typedef logic [DWORD_W-1:0] dword_t;

  // Primitives, K28.3 or K28.5 in byte 0
  localparam dword_t PRIM_ALIGN = 32'h7B4A4ABC;
  localparam dword_t PRIM_SYNC  = 32'hB5B5957C;
  localparam dword_t PRIM_X_RDY = 32'h5757B57C;
  localparam dword_t PRIM_R_RDY = 32'h4A4A957C;
  localparam dword_t PRIM_R_IP  = 32'h5555B57C;
  localparam dword_t PRIM_R_OK  = 32'h3535B57C;
  localparam dword_t PRIM_R_ERR = 32'h5656B57C;
  localparam dword_t PRIM_SOF   = 32'h3737B57C;
  localparam dword_t PRIM_EOF   = 32'hD5D5B57C;
  localparam dword_t PRIM_WTRM  = 32'h5858B57C;

  // Frame CRC
  localparam dword_t CRC_SEED = 32'h52325032;
  localparam dword_t CRC_POLY = 32'h04C11DB7;

  typedef enum logic [2:0] {
    RESET,
    COMRESET,
    COMWAKE,
    WAIT_ALIGN,
    READY
  } phy_state_e;

  typedef enum logic [3:0] {
    IDLE,
    TX_RDY,
    TX_SOF,
    TX_DATA,
    TX_CRC,
    TX_EOF,
    TX_WTRM,
    RX_RDY,
    RX_DATA,
    RX_RESP
  } link_state_e;

endpackage

/* design/sata_stack.sv */
// SATA host stack top
`timescale 1ns/10ps

module sata_stack import sata_prim_pkg::*, sata_cmd_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       platform_ready,
  output logic       linkup,
  input  logic       cmd_req,
  output logic       cmd_ack,
  input  ata_cmd_e   hard_drive_command,
  input  features_t  user_features,
  input  count_t     sector_count,
  input  lba_t       sector_address,
  output logic       sata_busy,
  output logic       hard_drive_error,
  output logic       link_error,
  output logic       d2h_reg_stb,
  output logic       d2h_interrupt,
  output logic [7:0] d2h_status,
  output logic [7:0] d2h_error,
  output logic [7:0] d2h_device,
  output lba_t       d2h_lba,
  output count_t     d2h_sector_count,
  output dword_t     tx_dout,
  output logic [3:0] tx_is_k,
  output logic       tx_comm_reset,
  output logic       tx_comm_wake,
  input  dword_t     rx_din,
  input  logic [3:0] rx_is_k,
  input  logic       comm_init_detect,
  input  logic       comm_wake_detect
);

  dword_t    phy_tx_dout;
  logic      phy_tx_is_k;
  dword_t    ll_tx_dout;
  logic      ll_tx_is_k;
  logic      layer_rst_n;
  logic      write_start;
  dword_t    write_data;
  logic      write_strobe;
  logic      write_done;
  logic      ll_xmit_error;
  dword_t    read_data;
  logic      read_strobe;
  logic      read_finished;
  logic      read_crc_ok;
  logic      xmit_error;
  logic      send_stb;
  ata_cmd_e  h2d_command;
  features_t h2d_features;
  lba_t      h2d_lba;
  count_t    h2d_sector_count;

  // Upper layers stay in reset until the lane is up
  assign layer_rst_n = arst_n & linkup;

  sata_phy_layer i_phy (
    .clk              (clk),
    .arst_n           (arst_n),
    .platform_ready   (platform_ready),
    .comm_init_detect (comm_init_detect),
    .comm_wake_detect (comm_wake_detect),
    .rx_din           (rx_din),
    .rx_is_k          (rx_is_k),
    .tx_comm_reset    (tx_comm_reset),
    .tx_comm_wake     (tx_comm_wake),
    .phy_tx_dout      (phy_tx_dout),
    .phy_tx_is_k      (phy_tx_is_k),
    .phy_ready        (linkup)
  );

  sata_link_layer i_link (
    .clk           (clk),
    .arst_n        (layer_rst_n),
    .phy_ready     (linkup),
    .rx_din        (rx_din),
    .rx_is_k       (rx_is_k),
    .ll_tx_dout    (ll_tx_dout),
    .ll_tx_is_k    (ll_tx_is_k),
    .write_start   (write_start),
    .write_data    (write_data),
    .write_strobe  (write_strobe),
    .write_done    (write_done),
    .xmit_error    (ll_xmit_error),
    .read_data     (read_data),
    .read_strobe   (read_strobe),
    .read_finished (read_finished),
    .read_crc_ok   (read_crc_ok)
  );

  sata_transport_layer i_transport (
    .clk              (clk),
    .arst_n           (layer_rst_n),
    .send_stb         (send_stb),
    .h2d_command      (h2d_command),
    .h2d_features     (h2d_features),
    .h2d_lba          (h2d_lba),
    .h2d_sector_count (h2d_sector_count),
    .write_start      (write_start),
    .write_data       (write_data),
    .write_strobe     (write_strobe),
    .write_done       (write_done),
    .ll_xmit_error    (ll_xmit_error),
    .read_data        (read_data),
    .read_strobe      (read_strobe),
    .read_finished    (read_finished),
    .read_crc_ok      (read_crc_ok),
    .xmit_error       (xmit_error),
    .d2h_reg_stb      (d2h_reg_stb),
    .d2h_interrupt    (d2h_interrupt),
    .d2h_status       (d2h_status),
    .d2h_error        (d2h_error),
    .d2h_device       (d2h_device),
    .d2h_lba          (d2h_lba),
    .d2h_sector_count (d2h_sector_count)
  );

  sata_command_layer i_command (
    .clk                (clk),
    .arst_n             (layer_rst_n),
    .linkup             (linkup),
    .cmd_req            (cmd_req),
    .cmd_ack            (cmd_ack),
    .hard_drive_command (hard_drive_command),
    .user_features      (user_features),
    .sector_count       (sector_count),
    .sector_address     (sector_address),
    .sata_busy          (sata_busy),
    .hard_drive_error   (hard_drive_error),
    .link_error         (link_error),
    .send_stb           (send_stb),
    .h2d_command        (h2d_command),
    .h2d_features       (h2d_features),
    .h2d_lba            (h2d_lba),
    .h2d_sector_count   (h2d_sector_count),
    .d2h_reg_stb        (d2h_reg_stb),
    .d2h_status         (d2h_status),
    .xmit_error         (xmit_error)
  );

  // Phy owns the lane until linkup
  assign tx_dout = linkup ? ll_tx_dout : phy_tx_dout;
  assign tx_is_k = {4{linkup ? ll_tx_is_k : phy_tx_is_k}};

endmodule

/* design/sata_transport_layer.sv */
// SATA register FIS transport
`timescale 1ns/10ps

module sata_transport_layer import sata_prim_pkg::*, sata_cmd_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      send_stb,
  input  ata_cmd_e  h2d_command,
  input  features_t h2d_features,
  input  lba_t      h2d_lba,
  input  count_t    h2d_sector_count,
  output logic      write_start,
  output dword_t    write_data,
  input  logic      write_strobe,
  input  logic      write_done,
  input  logic      ll_xmit_error,
  input  dword_t    read_data,
  input  logic      read_strobe,
  input  logic      read_finished,
  input  logic      read_crc_ok,
  output logic      xmit_error,
  output logic      d2h_reg_stb,
  output logic      d2h_interrupt,
  output logic [7:0] d2h_status,
  output logic [7:0] d2h_error,
  output logic [7:0] d2h_device,
  output lba_t      d2h_lba,
  output count_t    d2h_sector_count
);

  dword_t     h2d_sr [FIS_DWORDS];
  dword_t     rx_fis [FIS_DWORDS];
  logic [2:0] rx_cnt;
  logic       rx_good;

  // H2D register FIS, byte 0 in the low bits
  always_ff @(posedge clk) begin
    if (send_stb) begin
      h2d_sr[0] <= {h2d_features[7:0], h2d_command, 8'h80, REG_H2D};
      h2d_sr[1] <= {DEVICE_LBA_MODE, h2d_lba[23:0]};
      h2d_sr[2] <= {h2d_features[15:8], h2d_lba[47:24]};
      h2d_sr[3] <= {16'h0000, h2d_sector_count};
      h2d_sr[4] <= '0;
    end else if (write_strobe) begin
      for (int i = 0; i < FIS_DWORDS - 1; i++) begin
        h2d_sr[i] <= h2d_sr[i+1];
      end
      h2d_sr[FIS_DWORDS-1] <= '0;
    end
  end

  assign write_data = h2d_sr[0];

  always_ff @(posedge clk) begin
    if (read_strobe && rx_cnt < FIS_DWORDS) begin
      rx_fis[rx_cnt] <= read_data;
    end
  end

  // Good CRC, right type and exact length
  assign rx_good = read_finished && read_crc_ok && (rx_cnt == 3'(FIS_DWORDS)) &&
                   (rx_fis[0][7:0] == REG_D2H);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      write_start <= 1'b0;
      xmit_error  <= 1'b0;
      d2h_reg_stb <= 1'b0;
      rx_cnt      <= '0;
    end else begin
      write_start <= send_stb;
      xmit_error  <= write_done && ll_xmit_error;
      d2h_reg_stb <= rx_good;
      if (read_finished) begin
        rx_cnt <= '0;
      end else if (read_strobe && rx_cnt != 3'd7) begin
        rx_cnt <= rx_cnt + 3'd1;
      end
    end
  end

  // Fields only change on an accepted frame
  always_ff @(posedge clk) begin
    if (rx_good) begin
      d2h_interrupt    <= rx_fis[0][14];
      d2h_status       <= rx_fis[0][23:16];
      d2h_error        <= rx_fis[0][31:24];
      d2h_lba          <= {rx_fis[2][23:0], rx_fis[1][23:0]};
      d2h_device       <= rx_fis[1][31:24];
      d2h_sector_count <= rx_fis[3][15:0];
    end
  end

endmodule

/* sources.f */
design/sata_prim_pkg.sv
design/sata_cmd_pkg.sv
design/sata_crc.sv
design/sata_phy_layer.sv
design/sata_link_layer.sv
design/sata_transport_layer.sv
design/sata_command_layer.sv
design/sata_stack.sv
verif/sata_stack_asserts.sv
verif/tb_sata_stack.sv

/* verif/sata_stack_asserts.sv */
// SATA stack protocol checks
`timescale 1ns/10ps

module sata_stack_asserts (
  input logic clk,
  input logic arst_n,
  input logic cmd_req,
  input logic cmd_ack,
  input logic tx_comm_reset,
  input logic tx_comm_wake,
  input logic linkup
);

  int fail_count = 0;

  // Ack may only answer an open request
  ack_rise_in_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cmd_ack) |-> cmd_req)
    else begin
      fail_count++;
      $error("cmd_ack rose while cmd_req was low");
    end

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(cmd_ack) |-> !$past(cmd_req))
    else begin
      fail_count++;
      $error("cmd_ack fell before cmd_req was released");
    end

  // OOB bursts are exclusive
  oob_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(tx_comm_reset && tx_comm_wake))
    else begin
      fail_count++;
      $error("COMRESET and COMWAKE driven together");
    end

  linkup_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    !$fell(linkup))
    else begin
      fail_count++;
      $error("linkup dropped after bring-up");
    end

endmodule

bind sata_stack sata_stack_asserts i_asserts (
  .clk           (clk),
  .arst_n        (arst_n),
  .cmd_req       (cmd_req),
  .cmd_ack       (cmd_ack),
  .tx_comm_reset (tx_comm_reset),
  .tx_comm_wake  (tx_comm_wake),
  .linkup        (linkup)
);

/* verif/tb_sata_stack.sv */
// SATA stack testbench
`timescale 1ns/10ps

module tb_sata_stack import sata_prim_pkg::*, sata_cmd_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RESET_CYCLES   = 8;

  logic       clk;
  logic       arst_n;
  logic       platform_ready;
  logic       linkup;
  logic       cmd_req;
  logic       cmd_ack;
  ata_cmd_e   hard_drive_command;
  features_t  user_features;
  count_t     sector_count;
  lba_t       sector_address;
  logic       sata_busy;
  logic       hard_drive_error;
  logic       link_error;
  logic       d2h_reg_stb;
  logic       d2h_interrupt;
  logic [7:0] d2h_status;
  logic [7:0] d2h_error;
  logic [7:0] d2h_device;
  lba_t       d2h_lba;
  count_t     d2h_sector_count;
  dword_t     tx_dout;
  logic [3:0] tx_is_k;
  logic       tx_comm_reset;
  logic       tx_comm_wake;
  dword_t     rx_din;
  logic [3:0] rx_is_k;
  logic       comm_init_detect;
  logic       comm_wake_detect;
  int         cycle_cnt = 0;

  sata_stack i_dut (
    .clk                (clk),
    .arst_n             (arst_n),
    .platform_ready     (platform_ready),
    .linkup             (linkup),
    .cmd_req            (cmd_req),
    .cmd_ack            (cmd_ack),
    .hard_drive_command (hard_drive_command),
    .user_features      (user_features),
    .sector_count       (sector_count),
    .sector_address     (sector_address),
    .sata_busy          (sata_busy),
    .hard_drive_error   (hard_drive_error),
    .link_error         (link_error),
    .d2h_reg_stb        (d2h_reg_stb),
    .d2h_interrupt      (d2h_interrupt),
    .d2h_status         (d2h_status),
    .d2h_error          (d2h_error),
    .d2h_device         (d2h_device),
    .d2h_lba            (d2h_lba),
    .d2h_sector_count   (d2h_sector_count),
    .tx_dout            (tx_dout),
    .tx_is_k            (tx_is_k),
    .tx_comm_reset      (tx_comm_reset),
    .tx_comm_wake       (tx_comm_wake),
    .rx_din             (rx_din),
    .rx_is_k            (rx_is_k),
    .comm_init_detect   (comm_init_detect),
    .comm_wake_detect   (comm_wake_detect)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("** Error @ %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // One CRC step, MSB of the dword first
  function automatic dword_t crc_fold(input dword_t crc_in, input dword_t data);
    dword_t c;
    c = crc_in;
    for (int b = DWORD_W - 1; b >= 0; b--) begin
      if (c[DWORD_W-1] ^ data[b]) begin
        c = (c << 1) ^ CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  // Expected H2D dword from the current user request
  function automatic dword_t h2d_dword(input int idx);
    dword_t d;
    d = '0;
    case (idx)
      0: begin
        d[7:0]   = REG_H2D;
        d[15:8]  = 8'h80;
        d[23:16] = hard_drive_command;
        d[31:24] = user_features[7:0];
      end
      1: begin
        d[23:0]  = sector_address[23:0];
        d[31:24] = DEVICE_LBA_MODE;
      end
      2: begin
        d[23:0]  = sector_address[47:24];
        d[31:24] = user_features[15:8];
      end
      3: begin
        d[15:0] = sector_count;
      end
      default: begin
        d = '0;
      end
    endcase
    return d;
  endfunction

  task automatic drive_rx(input dword_t d, input logic k);
    @(posedge clk);
    rx_din  <= d;
    rx_is_k <= k ? 4'b0001 : 4'b0000;
  endtask

  // Wait for a primitive on the transmit port
  task automatic wait_tx(input dword_t prim);
    @(negedge clk);
    while (!(tx_dout == prim && tx_is_k == 4'hf)) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_ack();
    @(negedge clk);
    while (!cmd_ack) begin
      @(negedge clk);
    end
  endtask

  task automatic issue_request(input ata_cmd_e cmd, input features_t feat,
                               input count_t cnt, input lba_t lba);
    @(posedge clk);
    hard_drive_command <= cmd;
    user_features      <= feat;
    sector_count       <= cnt;
    sector_address     <= lba;
    cmd_req            <= 1'b1;
  endtask

  task automatic finish_handshake();
    @(posedge clk);
    cmd_req <= 1'b0;
    @(negedge clk);
    while (cmd_ack) begin
      @(negedge clk);
    end
    check_eq(sata_busy, 1'b0, "sata_busy after handshake");
  endtask

  // Device side of OOB, answering each burst after a short delay
  task automatic answer_oob();
    repeat (4) begin
      @(negedge clk);
      check_eq(tx_comm_reset, 1'b0, "COMRESET before platform_ready");
    end
    @(posedge clk);
    platform_ready <= 1'b1;
    @(negedge clk);
    while (!tx_comm_reset) begin
      check_eq(tx_comm_wake, 1'b0, "COMWAKE before COMRESET");
      @(negedge clk);
    end
    repeat (4) begin
      @(negedge clk);
      check_eq(tx_comm_reset, 1'b1, "COMRESET held until COMINIT");
      check_eq(tx_comm_wake, 1'b0, "COMWAKE before COMINIT");
    end
    @(posedge clk);
    comm_init_detect <= 1'b1;
    @(posedge clk);
    comm_init_detect <= 1'b0;
    @(negedge clk);
    while (!tx_comm_wake) begin
      @(negedge clk);
    end
    check_eq(tx_comm_reset, 1'b0, "COMRESET released");
    repeat (4) begin
      @(negedge clk);
      check_eq(tx_comm_wake, 1'b1, "COMWAKE held until device wake");
    end
    @(posedge clk);
    comm_wake_detect <= 1'b1;
    @(posedge clk);
    comm_wake_detect <= 1'b0;
    @(negedge clk);
    while (tx_comm_wake) begin
      @(negedge clk);
    end
    repeat (3) begin
      @(negedge clk);
      check_eq(tx_dout, PRIM_ALIGN, "ALIGN before linkup");
      check_eq(tx_is_k, 4'hf, "ALIGN is_k");
      check_eq(linkup, 1'b0, "linkup before device ALIGN");
    end
    drive_rx(PRIM_ALIGN, 1'b1);
    drive_rx(PRIM_SYNC, 1'b1);
    @(negedge clk);
    while (!linkup) begin
      @(negedge clk);
    end
  endtask

  // Device receives an H2D frame and replies R_OK or R_ERR
  task automatic receive_h2d_frame(input logic reply_err);
    dword_t crc;
    crc = CRC_SEED;
    wait_tx(PRIM_X_RDY);
    check_eq(sata_busy, 1'b1, "sata_busy at X_RDY");
    repeat (3) begin
      @(negedge clk);
      check_eq(tx_dout, PRIM_X_RDY, "X_RDY repeats until R_RDY");
    end
    drive_rx(PRIM_R_RDY, 1'b1);
    drive_rx(PRIM_R_IP, 1'b1);
    wait_tx(PRIM_SOF);
    for (int i = 0; i < FIS_DWORDS; i++) begin
      @(negedge clk);
      check_eq(tx_is_k, 4'h0, "H2D data is_k");
      check_eq(tx_dout, h2d_dword(i), "H2D data dword");
      check_eq(sata_busy, 1'b1, "sata_busy in frame");
      check_eq(cmd_ack, 1'b0, "cmd_ack in frame");
      crc = crc_fold(crc, h2d_dword(i));
    end
    @(negedge clk);
    check_eq(tx_is_k, 4'h0, "H2D CRC is_k");
    check_eq(tx_dout, crc, "H2D frame CRC");
    @(negedge clk);
    check_eq(tx_dout, PRIM_EOF, "EOF after CRC");
    check_eq(tx_is_k, 4'hf, "EOF is_k");
    repeat (2) begin
      @(negedge clk);
      check_eq(tx_dout, PRIM_WTRM, "WTRM until reply");
    end
    drive_rx(reply_err ? PRIM_R_ERR : PRIM_R_OK, 1'b1);
    drive_rx(PRIM_SYNC, 1'b1);
    wait_tx(PRIM_SYNC);
  endtask

  // Device sends a D2H register FIS, optionally with a broken CRC
  task automatic send_d2h_frame(input logic [7:0] status, input logic [7:0] error,
                                input lba_t lba, input count_t count, input logic bad_crc);
    dword_t fis [FIS_DWORDS];
    dword_t crc;
    int     stb_seen;
    fis[0] = {error, status, 8'h40, 8'h34};
    fis[1] = {8'h40, lba[23:0]};
    fis[2] = {8'h00, lba[47:24]};
    fis[3] = {16'h0000, count};
    fis[4] = '0;
    crc = CRC_SEED;
    for (int i = 0; i < FIS_DWORDS; i++) begin
      crc = crc_fold(crc, fis[i]);
    end
    if (bad_crc) begin
      crc[0] = ~crc[0];
    end
    stb_seen = 0;
    drive_rx(PRIM_X_RDY, 1'b1);
    wait_tx(PRIM_R_RDY);
    drive_rx(PRIM_SOF, 1'b1);
    for (int i = 0; i < FIS_DWORDS; i++) begin
      drive_rx(fis[i], 1'b0);
    end
    drive_rx(crc, 1'b0);
    drive_rx(PRIM_EOF, 1'b1);
    drive_rx(PRIM_WTRM, 1'b1);
    @(negedge clk);
    while (!(tx_is_k == 4'hf && (tx_dout == PRIM_R_OK || tx_dout == PRIM_R_ERR))) begin
      @(negedge clk);
    end
    check_eq(tx_dout, bad_crc ? PRIM_R_ERR : PRIM_R_OK, "host reply to D2H frame");
    // Register strobe lands within a few slots of the reply
    for (int i = 0; i < 4; i++) begin
      if (d2h_reg_stb) begin
        stb_seen++;
        check_eq(d2h_status, status, "d2h_status");
        check_eq(d2h_error, error, "d2h_error");
        check_eq(d2h_lba, lba, "d2h_lba");
        check_eq(d2h_sector_count, count, "d2h_sector_count");
        check_eq(d2h_interrupt, 1'b1, "d2h_interrupt");
        check_eq(d2h_device, 8'h40, "d2h_device");
      end
      @(negedge clk);
    end
    check_eq(stb_seen, bad_crc ? 0 : 1, "d2h_reg_stb pulse count");
    drive_rx(PRIM_SYNC, 1'b1);
    wait_tx(PRIM_SYNC);
  endtask

  task automatic bring_up();
    @(negedge clk);
    check_eq(linkup, 1'b0, "linkup after reset");
    check_eq(cmd_ack, 1'b0, "cmd_ack after reset");
    check_eq(sata_busy, 1'b0, "sata_busy after reset");
    check_eq(d2h_reg_stb, 1'b0, "d2h_reg_stb after reset");
    check_eq(tx_comm_reset, 1'b0, "tx_comm_reset after reset");
    check_eq(tx_comm_wake, 1'b0, "tx_comm_wake after reset");
    check_eq(tx_dout, PRIM_ALIGN, "ALIGN after reset");
    check_eq(tx_is_k, 4'hf, "ALIGN is_k after reset");
    answer_oob();
    @(negedge clk);
    check_eq(linkup, 1'b1, "linkup stays high");
    check_eq(tx_dout, PRIM_SYNC, "SYNC after linkup");
    check_eq(tx_is_k, 4'hf, "SYNC is_k");
  endtask

  task automatic command_frame();
    issue_request(IDENTIFY, 16'h0000, 16'h0001, 48'h0);
    receive_h2d_frame(1'b0);
    check_eq(sata_busy, 1'b1, "sata_busy waiting for D2H");
    check_eq(cmd_ack, 1'b0, "cmd_ack before D2H");
  endtask

  task automatic good_response();
    logic [7:0] status;
    status = 8'h51;
    send_d2h_frame(status, 8'h04, 48'h0000_1234_5678, 16'h0001, 1'b0);
    wait_ack();
    check_eq(hard_drive_error, status[0], "hard_drive_error from status");
    check_eq(link_error, 1'b0, "link_error on good response");
    check_eq(sata_busy, 1'b0, "sata_busy at ack");
    finish_handshake();
  endtask

  task automatic bad_crc_retry();
    issue_request(READ_VERIFY_EXT, 16'hBEEF, 16'h0102, 48'h1122_3344_5566);
    receive_h2d_frame(1'b0);
    send_d2h_frame(8'h50, 8'h00, 48'h1122_3344_5566, 16'h0102, 1'b1);
    check_eq(cmd_ack, 1'b0, "cmd_ack after bad CRC");
    check_eq(sata_busy, 1'b1, "sata_busy after bad CRC");
    send_d2h_frame(8'h50, 8'h00, 48'h1122_3344_5566, 16'h0102, 1'b0);
    wait_ack();
    check_eq(hard_drive_error, 1'b0, "hard_drive_error on clean status");
    check_eq(link_error, 1'b0, "link_error after resend");
    finish_handshake();
  endtask

  task automatic transmit_error();
    issue_request(SET_FEATURES, 16'h0003, 16'h0046, 48'h0000_00A0_0001);
    receive_h2d_frame(1'b1);
    wait_ack();
    check_eq(link_error, 1'b1, "link_error on R_ERR");
    check_eq(hard_drive_error, 1'b0, "hard_drive_error on R_ERR");
    check_eq(sata_busy, 1'b0, "sata_busy on R_ERR");
    finish_handshake();
  endtask

  initial begin
    arst_n             = 1'b0;
    platform_ready     = 1'b0;
    comm_init_detect   = 1'b0;
    comm_wake_detect   = 1'b0;
    cmd_req            = 1'b0;
    hard_drive_command = IDENTIFY;
    user_features      = '0;
    sector_count       = '0;
    sector_address     = '0;
    rx_din             = PRIM_SYNC;
    rx_is_k            = 4'b0001;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    bring_up();
    command_frame();
    good_response();
    bad_crc_retry();
    transmit_error();
    repeat (4) @(posedge clk);
    if (i_dut.i_asserts.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "Bound assertions reported failures");
    end
  end

endmodule
